// File: design/sdram_settings.svh
`ifndef SDRAM_SETTINGS_SVH
`define SDRAM_SETTINGS_SVH

// CAS latency
`define SDRAM_CAS 2
// Read burst length as log2, 3 gives bursts of eight
`define SDRAM_BURST 3

// Power-up wait and refresh period
`define SDRAM_TINIT 13300
`define SDRAM_TREFC 1039

// Timing counts in clkSDRAM cycles
`define SDRAM_TRC 8
`define SDRAM_TRAS 6
`define SDRAM_TRP 2
`define SDRAM_TMRD 2
`define SDRAM_TRCD 2
// Write recovery before precharge
`define SDRAM_TDPL 2

`endif

// File: design/sdram_pkg.sv
package sdram_pkg;

	typedef enum int unsigned {
		NOP,
		BST,
		READ,
		WRITE,
		ACT,
		PRE,
		PALL,
		REF,
		MRS
	} sdram_cmd_t;

	// User request, address is {ba, row, col}
	typedef struct packed {
		logic we;
		logic [1:0] ba;
		logic [12:0] row;
		logic [8:0] col;
		logic [15:0] data;
	} mem_req_t;

	// One returned read word
	typedef struct packed {
		logic [23:0] addr;
		logic [15:0] data;
	} rd_resp_t;

	typedef struct packed {
		logic cke;
		logic cs_n;
		logic ras_n;
		logic cas_n;
		logic we_n;
		logic [1:0] ba;
		logic [12:0] addr;
		logic [1:0] dqm;
	} dram_pins_t;

	typedef struct packed {
		logic active;
		logic match;
		logic pre_ok;
		logic act_ok;
		logic rw_ok;
	} bank_status_t;

endpackage

// File: design/sdram_req_buffer.sv
`timescale 1ns/100ps

module sdram_req_buffer (
	input logic clkSDRAM,
	input logic n_reset,
	input logic req,
	input sdram_pkg::mem_req_t req_in,
	input logic issued,
	output logic rdy,
	output sdram_pkg::mem_req_t head,
	output logic pending
);

	import sdram_pkg::*;

	mem_req_t in_q;
	logic in_valid;
	logic advance;

	// Issue stage is free or being emptied this cycle
	assign advance = ~pending | issued;
	assign rdy = ~in_valid;

	always_ff @(posedge clkSDRAM, negedge n_reset) begin
		if (!n_reset) begin
			in_valid <= 1'b0;
			pending <= 1'b0;
			head <= '0;
		end else begin
			if (rdy)
				in_valid <= req;
			else if (advance)
				in_valid <= 1'b0;
			if (advance) begin
				pending <= in_valid;
				if (in_valid)
					head <= in_q;
			end
		end
	end

	always_ff @(posedge clkSDRAM)
		if (rdy)
			in_q <= req_in;

endmodule

// File: design/sdram_bank.sv
`timescale 1ns/100ps
`include "sdram_settings.svh"

module sdram_bank (
	input logic clkSDRAM,
	input logic n_reset,
	input logic sel,
	input sdram_pkg::sdram_cmd_t cmd,
	input logic [12:0] row,
	output sdram_pkg::bank_status_t status
);

	import sdram_pkg::*;

	logic active;
	logic [12:0] open_row;
	logic [3:0] t_rc, t_ras, t_rp, t_rcd, t_dpl;

	function automatic logic [3:0] count_down(input logic [3:0] value);
		return (value == 4'd0) ? 4'd0 : value - 4'd1;
	endfunction

	always_ff @(posedge clkSDRAM, negedge n_reset) begin
		if (!n_reset) begin
			active <= 1'b0;
			t_rc <= '0;
			t_ras <= '0;
			t_rp <= '0;
			t_rcd <= '0;
			t_dpl <= '0;
		end else begin
			t_rc <= count_down(t_rc);
			t_ras <= count_down(t_ras);
			t_rp <= count_down(t_rp);
			t_rcd <= count_down(t_rcd);
			t_dpl <= count_down(t_dpl);
			if (sel) begin
				case (cmd)
				ACT: begin
					active <= 1'b1;
					t_rc <= 4'(`SDRAM_TRC - 1);
					t_ras <= 4'(`SDRAM_TRAS - 1);
					t_rcd <= 4'(`SDRAM_TRCD - 1);
				end
				PRE, PALL: begin
					active <= 1'b0;
					t_rp <= 4'(`SDRAM_TRP - 1);
				end
				WRITE: t_dpl <= 4'(`SDRAM_TDPL - 1);
				default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clkSDRAM)
		if (sel && cmd == ACT)
			open_row <= row;

	assign status.active = active;
	assign status.match = open_row == row;
	assign status.act_ok = t_rc == 4'd0 && t_rp == 4'd0;
	assign status.pre_ok = t_ras == 4'd0 && t_dpl == 4'd0;
	assign status.rw_ok = t_rcd == 4'd0;

endmodule

// File: design/sdram_read_return.sv
`timescale 1ns/100ps
`include "sdram_settings.svh"

module sdram_read_return (
	input logic clkSDRAM,
	input logic n_reset,
	input logic rd_issue,
	input logic [23:0] rd_addr,
	input logic [15:0] dq,
	output sdram_pkg::rd_resp_t resp,
	output logic rdy_out
);

	import sdram_pkg::*;

	// Together with the capture register this gives CAS+2 stages
	localparam int DEPTH = `SDRAM_CAS + 1;
	localparam int BW = `SDRAM_BURST;

	logic rd_line [DEPTH];
	logic [23:0] addr_line [DEPTH];
	logic [BW-1:0] words_left;
	logic first;

	assign first = rd_line[DEPTH-1];

	always_ff @(posedge clkSDRAM, negedge n_reset) begin
		if (!n_reset) begin
			for (int i = 0; i < DEPTH; i++)
				rd_line[i] <= 1'b0;
		end else begin
			rd_line[0] <= rd_issue;
			for (int i = 1; i < DEPTH; i++)
				rd_line[i] <= rd_line[i-1];
		end
	end

	always_ff @(posedge clkSDRAM) begin
		addr_line[0] <= rd_addr;
		for (int i = 1; i < DEPTH; i++)
			addr_line[i] <= addr_line[i-1];
	end

	// Burst of eight words from the first capture on
	always_ff @(posedge clkSDRAM, negedge n_reset) begin
		if (!n_reset) begin
			rdy_out <= 1'b0;
			words_left <= '0;
		end else if (first) begin
			rdy_out <= 1'b1;
			words_left <= '1;
		end else if (words_left != '0) begin
			rdy_out <= 1'b1;
			words_left <= words_left - 1'b1;
		end else begin
			rdy_out <= 1'b0;
		end
	end

	// Low address bits wrap inside the aligned burst
	always_ff @(posedge clkSDRAM) begin
		resp.data <= dq;
		if (first)
			resp.addr <= addr_line[DEPTH-1];
		else
			resp.addr[BW-1:0] <= resp.addr[BW-1:0] + 1'b1;
	end

endmodule

// File: design/sdram_ctrl.sv
`timescale 1ns/100ps
`include "sdram_settings.svh"

module sdram_ctrl (
	input logic clkSDRAM,
	input logic n_reset,
	input sdram_pkg::mem_req_t head,
	input logic pending,
	input sdram_pkg::bank_status_t bank_st [4],
	output sdram_pkg::sdram_cmd_t cmd,
	output logic issued,
	output logic rd_issue,
	output sdram_pkg::dram_pins_t pins,
	output logic dq_oe,
	output logic [15:0] dq_out
);

	import sdram_pkg::*;

	localparam int BURST_LEN = 2 ** `SDRAM_BURST;
	// Bus turnaround after a read burst
	localparam logic [4:0] WR_HOLD = 5'(`SDRAM_CAS + BURST_LEN + 2 - 1);
	localparam logic [15:0] EXEC_LEN = 16'(`SDRAM_TREFC - `SDRAM_TRP - `SDRAM_TRC - 2);

	typedef enum logic [2:0] {
		Reset, Init, InitPall, Precharge, Refresh, Execute, Active
	} state_t;

	state_t state, state_next;
	logic [15:0] cnt, cnt_load;
	logic mode;
	logic [`SDRAM_BURST-1:0] burst;
	logic [4:0] wr_delay;
	bank_status_t head_st;
	sdram_cmd_t exec_cmd;
	dram_pins_t pins_next;

	always_ff @(posedge clkSDRAM, negedge n_reset) begin
		if (!n_reset) begin
			state <= Reset;
			cnt <= '0;
		end else if (cnt == 16'd0) begin
			state <= state_next;
			cnt <= cnt_load;
		end else begin
			cnt <= cnt - 16'd1;
		end
	end

	always_ff @(posedge clkSDRAM, negedge n_reset) begin
		if (!n_reset) begin
			mode <= 1'b0;
			burst <= '0;
			wr_delay <= '0;
		end else begin
			if (cmd == MRS)
				mode <= 1'b1;
			if (cmd == READ)
				burst <= '1;
			else if (burst != '0)
				burst <= burst - 1'b1;
			if (cmd == READ)
				wr_delay <= WR_HOLD;
			else if (wr_delay != 5'd0)
				wr_delay <= wr_delay - 5'd1;
		end
	end

	// Request command, margins keep the closing PALL legal
	always_comb begin
		head_st = bank_st[head.ba];
		exec_cmd = NOP;
		if (!head_st.active) begin
			if (head_st.act_ok && cnt >= 16'(`SDRAM_TRAS))
				exec_cmd = ACT;
		end else if (!head_st.match) begin
			if (head_st.pre_ok)
				exec_cmd = PRE;
		end else if (head_st.rw_ok) begin
			if (!head.we) begin
				if (cnt >= 16'(BURST_LEN))
					exec_cmd = READ;
			end else if (wr_delay == 5'd0 && cnt >= 16'(`SDRAM_TDPL)) begin
				exec_cmd = WRITE;
			end
		end
	end

	always_comb begin
		state_next = state;
		cnt_load = '0;
		cmd = NOP;
		case (state)
		Reset: begin
			state_next = Init;
			cnt_load = 16'(`SDRAM_TINIT - 1);
		end
		Init: begin
			state_next = InitPall;
			cnt_load = 16'(`SDRAM_TRP - 1);
			if (cnt == 16'd0)
				cmd = PALL;
		end
		InitPall, Precharge: begin
			state_next = (state == InitPall) ? Precharge : Refresh;
			cnt_load = 16'(`SDRAM_TRC - 1);
			if (cnt == 16'd0)
				cmd = REF;
		end
		Refresh: begin
			if (!mode) begin
				cnt_load = 16'(`SDRAM_TMRD - 1);
				if (cnt == 16'd0)
					cmd = MRS;
			end else begin
				state_next = Execute;
				cnt_load = EXEC_LEN;
			end
		end
		Execute: begin
			state_next = Active;
			if (pending && burst == '0)
				cmd = exec_cmd;
		end
		Active: begin
			state_next = Precharge;
			cnt_load = 16'(`SDRAM_TRP - 1);
			cmd = PALL;
		end
		default: state_next = Reset;
		endcase
	end

	assign issued = cmd == READ || cmd == WRITE;
	assign rd_issue = cmd == READ;

	always_comb begin
		pins_next.cke = 1'b1;
		pins_next.cs_n = 1'b0;
		{pins_next.ras_n, pins_next.cas_n, pins_next.we_n} = 3'b111;
		pins_next.ba = head.ba;
		pins_next.addr = {4'b0000, head.col};
		pins_next.dqm = 2'b00;
		case (cmd)
		BST: {pins_next.ras_n, pins_next.cas_n, pins_next.we_n} = 3'b110;
		READ: {pins_next.ras_n, pins_next.cas_n, pins_next.we_n} = 3'b101;
		WRITE: {pins_next.ras_n, pins_next.cas_n, pins_next.we_n} = 3'b100;
		ACT: begin
			{pins_next.ras_n, pins_next.cas_n, pins_next.we_n} = 3'b011;
			pins_next.addr = head.row;
		end
		PRE, PALL: begin
			{pins_next.ras_n, pins_next.cas_n, pins_next.we_n} = 3'b010;
			pins_next.addr[10] = cmd == PALL;
		end
		REF: {pins_next.ras_n, pins_next.cas_n, pins_next.we_n} = 3'b001;
		MRS: begin
			{pins_next.ras_n, pins_next.cas_n, pins_next.we_n} = 3'b000;
			// Single writes, CAS latency, sequential burst
			pins_next.ba = 2'b00;
			pins_next.addr = {3'b000, 1'b1, 2'b00, 3'(`SDRAM_CAS), 1'b0, 3'(`SDRAM_BURST)};
		end
		default: ;
		endcase
	end

	always_ff @(posedge clkSDRAM, negedge n_reset) begin
		if (!n_reset) begin
			pins <= '{cke: 1'b0, cs_n: 1'b1, ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1,
				ba: 2'b00, addr: 13'h0, dqm: 2'b00};
			dq_oe <= 1'b0;
		end else begin
			pins <= pins_next;
			dq_oe <= cmd == WRITE;
		end
	end

	always_ff @(posedge clkSDRAM)
		dq_out <= head.data;

endmodule

// File: design/sdram.sv
`timescale 1ns/100ps

module sdram (
	input logic clkSDRAM,
	input logic n_reset,
	input logic en,
	input logic req,
	input sdram_pkg::mem_req_t req_in,
	output logic rdy,
	output sdram_pkg::dram_pins_t dram,
	output logic dram_clk,
	inout wire [15:0] dq,
	output sdram_pkg::rd_resp_t resp,
	output logic rdy_out
);

	import sdram_pkg::*;

	mem_req_t head;
	logic pending, issued, rd_issue;
	sdram_cmd_t cmd;
	bank_status_t bank_st [4];
	logic [3:0] bank_sel;
	dram_pins_t pins;
	logic dq_oe;
	logic [15:0] dq_out;

	sdram_req_buffer buffer_inst (
		.clkSDRAM, .n_reset, .req, .req_in, .issued, .rdy, .head, .pending
	);

	// PALL closes every bank, other commands go to the head bank
	always_comb
		for (int i = 0; i < 4; i++)
			bank_sel[i] = cmd == PALL || head.ba == 2'(i);

	for (genvar i = 0; i < 4; i++) begin : gen_bank
		sdram_bank bank_inst (
			.clkSDRAM, .n_reset, .sel(bank_sel[i]), .cmd, .row(head.row),
			.status(bank_st[i])
		);
	end

	sdram_ctrl ctrl_inst (
		.clkSDRAM, .n_reset, .head, .pending, .bank_st,
		.cmd, .issued, .rd_issue, .pins, .dq_oe, .dq_out
	);

	sdram_read_return read_inst (
		.clkSDRAM, .n_reset, .rd_issue, .rd_addr({head.ba, head.row, head.col}),
		.dq, .resp, .rdy_out
	);

	always_comb begin
		dram = pins;
		dram.cs_n = ~en;
	end

	assign dram_clk = clkSDRAM;
	assign dq = dq_oe ? dq_out : 16'bz;

endmodule

// File: verification/sdram_model.sv
`timescale 1ns/100ps
`include "sdram_settings.svh"

module sdram_model (
	input logic clk,
	input sdram_pkg::dram_pins_t pins,
	inout wire [15:0] dq,
	output int refresh_count,
	output logic mrs_seen,
	output int error_count
);

	localparam int BW = `SDRAM_BURST;
	localparam int FIRST = `SDRAM_CAS - 1;
	localparam int LAST = `SDRAM_CAS - 1 + 2 ** `SDRAM_BURST;

	logic [15:0] mem [logic [23:0]];
	logic [12:0] open_row [4];
	logic row_open [4] = '{default: 1'b0};
	logic [23:0] rd_base;
	int rd_step = 0;
	logic drive_en = 1'b0;
	logic [15:0] dq_drv;
	int refreshes = 0;
	int errors = 0;
	logic mrs_done = 1'b0;
	logic [2:0] code;
	logic [23:0] addr;
	logic legal_init;

	assign dq = drive_en ? dq_drv : 16'bz;
	assign refresh_count = refreshes;
	assign error_count = errors;
	assign mrs_seen = mrs_done;
	assign code = {pins.ras_n, pins.cas_n, pins.we_n};
	assign addr = {pins.ba, open_row[pins.ba], pins.addr[8:0]};
	// NOP, REF, MRS or precharge-all
	assign legal_init = code == 3'b111 || code == 3'b001 || code == 3'b000
		|| (code == 3'b010 && pins.addr[10]);

	// Unwritten words read back a pattern of their own address
	function automatic logic [15:0] fill_word(input logic [23:0] a);
		return a[15:0] ^ {a[23:16], a[23:16]};
	endfunction

	function automatic logic [15:0] load(input logic [23:0] a);
		return mem.exists(a) ? mem[a] : fill_word(a);
	endfunction

	always @(posedge clk) begin
		logic [23:0] word_addr;
		// Word 0 goes on the bus CAS-1 edges after the READ is seen
		if (rd_step != 0) begin
			rd_step <= rd_step + 1;
			if (rd_step >= FIRST && rd_step < LAST) begin
				word_addr = rd_base;
				word_addr[BW-1:0] = rd_base[BW-1:0] + BW'(rd_step - FIRST);
				dq_drv <= load(word_addr);
				drive_en <= 1'b1;
			end else if (rd_step == LAST) begin
				drive_en <= 1'b0;
				rd_step <= 0;
			end
		end
		if (pins.cke && !pins.cs_n) begin
			if (!mrs_done && !legal_init) begin
				$display("Model saw command %b before the mode register load at %0t", code, $time);
				errors <= errors + 1;
			end
			case (code)
			3'b011: begin
				row_open[pins.ba] <= 1'b1;
				open_row[pins.ba] <= pins.addr;
			end
			3'b010:
				if (pins.addr[10]) begin
					for (int b = 0; b < 4; b++)
						row_open[b] <= 1'b0;
				end else begin
					row_open[pins.ba] <= 1'b0;
				end
			3'b001: refreshes <= refreshes + 1;
			3'b000: mrs_done <= 1'b1;
			3'b101:
				if (!row_open[pins.ba]) begin
					$display("Model saw READ to bank %0d with no open row at %0t", pins.ba, $time);
					errors <= errors + 1;
				end else begin
					rd_base <= addr;
					rd_step <= 1;
				end
			3'b100:
				if (!row_open[pins.ba]) begin
					$display("Model saw WRITE to bank %0d with no open row at %0t", pins.ba, $time);
					errors <= errors + 1;
				end else begin
					mem[addr] = dq;
				end
			default: ;
			endcase
		end
	end

endmodule

// File: verification/sdram_tb.sv
`timescale 1ns/100ps
`include "sdram_settings.svh"

module sdram_tb;

	import sdram_pkg::*;

	localparam int MAX_LINES = 64;
	localparam int BW = `SDRAM_BURST;
	localparam int BURST_LEN = 2 ** `SDRAM_BURST;
	localparam int IDLE = 3 * `SDRAM_TREFC;

	logic clkSDRAM = 1'b0;
	logic n_reset;
	logic en;
	logic req;
	mem_req_t req_in;
	logic rdy;
	dram_pins_t dram;
	logic dram_clk;
	wire [15:0] dq;
	rd_resp_t resp;
	logic rdy_out;

	int refresh_count;
	int model_errors;
	logic mrs_seen;

	logic [47:0] lines [MAX_LINES];
	logic [15:0] shadow [logic [23:0]];
	rd_resp_t expected [$];
	int errors = 0;
	int test_errors = 0;
	int checks = 0;
	int tests = 0;
	int reads = 0;
	int responses = 0;
	int model_base = 0;
	int cycles = 0;
	int limit = 0;
	int seed;
	logic early_rdy_out = 1'b0;

	sdram sdram_inst (
		.clkSDRAM, .n_reset, .en, .req, .req_in, .rdy, .dram, .dram_clk, .dq, .resp, .rdy_out
	);

	sdram_model model_inst (
		.clk(dram_clk), .pins(dram), .dq, .refresh_count, .mrs_seen,
		.error_count(model_errors)
	);

	always #10 clkSDRAM = ~clkSDRAM;

	always @(posedge clkSDRAM) begin
		cycles++;
		if (limit != 0 && cycles > limit) begin
			$display("Timeout after %0d cycles, the requests did not complete", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic logic [15:0] fill_word(input logic [23:0] a);
		return a[15:0] ^ {a[23:16], a[23:16]};
	endfunction

	function automatic string test_name(input int t);
		case (t)
		1: return "init sequence";
		2: return "write then read in one row";
		3: return "row changes in one bank";
		4: return "all four banks";
		5: return "back-to-back requests";
		default: return "refresh count";
		endcase
	endfunction

	task automatic note_error();
		errors++;
		test_errors++;
	endtask

	task automatic check_resp(input rd_resp_t actual, input rd_resp_t want);
		checks++;
		if (actual.addr !== want.addr) begin
			$display("Error resp.addr got %h expected %h", actual.addr, want.addr);
			note_error();
		end
		if (actual.data !== want.data) begin
			$display("Error resp.data at %h got %h expected %h", want.addr, actual.data,
				want.data);
			note_error();
		end
	endtask

	task automatic check_count(input string name, input int actual, input int low,
		input int high);
		checks++;
		if (actual < low || actual > high) begin
			if (low == high)
				$display("Error %s got %0h expected %0h", name, actual, low);
			else
				$display("Error %s got %0h expected at least %0h", name, actual, low);
			note_error();
		end
	endtask

	// Word k of a burst wraps inside the aligned group of eight
	task automatic expect_burst(input logic [23:0] start, input logic [15:0] first_data);
		rd_resp_t word;
		for (int k = 0; k < BURST_LEN; k++) begin
			word.addr = start;
			word.addr[BW-1:0] = start[BW-1:0] + BW'(k);
			word.data = shadow.exists(word.addr) ? shadow[word.addr] : fill_word(word.addr);
			if (k == 0)
				word.data = first_data;
			expected.push_back(word);
		end
	endtask

	task automatic send(input mem_req_t r);
		req = 1'b1;
		req_in = r;
		while (!rdy)
			@(negedge clkSDRAM);
		@(negedge clkSDRAM);
		req = 1'b0;
	endtask

	task automatic finish_test(input int t);
		while (expected.size() != 0)
			@(negedge clkSDRAM);
		check_count("model errors", model_errors - model_base, 0, 0);
		check_count("read words", responses, BURST_LEN * reads, BURST_LEN * reads);
		$display("Test %0d %s: %0d errors", t, test_name(t), test_errors);
		test_errors = 0;
		model_base = model_errors;
		tests++;
	endtask

	always @(negedge clkSDRAM) begin
		if (rdy_out) begin
			responses++;
			if (!mrs_seen)
				early_rdy_out = 1'b1;
			if (expected.size() == 0) begin
				$display("Read word at %h came back with no read outstanding", resp.addr);
				note_error();
			end else begin
				check_resp(resp, expected.pop_front());
			end
		end
	end

	initial begin
		int nreq;
		int cur;
		int gap;
		int start;
		int run_cycles;
		logic [3:0] tnum;
		logic [3:0] op;
		logic [23:0] addr;
		logic [15:0] data;
		mem_req_t r;
		en = 1'b1;
		req = 1'b0;
		req_in = '0;
		n_reset = 1'b0;
		seed = 32'h09ea_10d1;
		for (int i = 0; i < MAX_LINES; i++)
			lines[i] = '0;
		$readmemh("verification/sdram_testdata.txt", lines);
		nreq = 0;
		while (nreq < MAX_LINES && lines[nreq][43:40] != 4'h0)
			nreq++;
		limit = `SDRAM_TINIT + 4 * `SDRAM_TREFC * (nreq + 1) + IDLE + 10;
		repeat (10) @(negedge clkSDRAM);
		n_reset = 1'b1;
		start = cycles;

		// A read queued during init has to wait for the mode register load
		addr = 24'h000a18;
		r = '0;
		{r.ba, r.row, r.col} = addr;
		send(r);
		expect_burst(addr, fill_word(addr));
		reads++;

		while (!mrs_seen)
			@(negedge clkSDRAM);
		check_count("rdy_out during init", int'(early_rdy_out), 0, 0);
		finish_test(1);

		cur = 2;
		for (int i = 0; i < nreq; i++) begin
			{tnum, op, addr, data} = lines[i];
			if (int'(tnum) != cur) begin
				finish_test(cur);
				cur = int'(tnum);
			end
			r.we = op[0];
			{r.ba, r.row, r.col} = addr;
			r.data = op[0] ? data : 16'h0;
			if (!op[3]) begin
				gap = $random(seed) & 32'h7;
				repeat (gap) @(negedge clkSDRAM);
			end
			send(r);
			if (r.we) begin
				shadow[addr] = data;
			end else begin
				expect_burst(addr, data);
				reads++;
			end
		end
		finish_test(cur);

		repeat (IDLE) @(negedge clkSDRAM);
		run_cycles = cycles - start;
		check_count("refresh count", refresh_count,
			(run_cycles - `SDRAM_TINIT) / `SDRAM_TREFC - 1, 32'h7fff_ffff);
		finish_test(6);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: verification/sdram_testdata.txt
// Columns: test, op, word address {ba, row, col}, data
// op 1 write, 2 read burst with expected first word in data, plus 8 for no idle gap
2_1_000a10_1111
2_1_000a13_2222
2_2_000a12_0a12
2_2_000a10_1111
3_1_400e20_3333
3_1_401205_4444
3_2_400e20_3333
3_2_401205_4444
3_2_400e22_4e62
4_1_8201ff_5555
4_1_fffe33_6666
4_2_8201ff_5555
4_2_fffe33_6666
4_2_000a11_0a11
4_2_401200_5240
5_9_810000_7777
5_9_c00040_8888
5_a_810000_7777
5_a_c00040_8888
5_9_400e21_9999
5_a_400e20_3333
5_a_8201f8_837a

// File: project.f
+incdir+design
design/sdram_pkg.sv
design/sdram_req_buffer.sv
design/sdram_bank.sv
design/sdram_read_return.sv
design/sdram_ctrl.sv
design/sdram.sv
verification/sdram_model.sv
verification/sdram_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP ?= sdram_tb
FILELIST ?= project.f

OBJDIR := obj_dir
SIM := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)
PASS := All checks passed

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJDIR)
